/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_snowball
RTL_TOP    := snowball_top
FLIST      := flist.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

/* dual_clock_ram.sv */
`timescale 1ns/1ns
`include "snowball_params.svh"

module dual_clock_ram #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                   rclk,
  input  logic [`SNOW_IDX_W-1:0] raddr,
  input  logic                   re,
  input  logic                   wclk,
  input  logic [`SNOW_IDX_W-1:0] waddr,
  input  logic                   we,
  input  payload_t               wdata,
  output payload_t               rdata
);

  payload_t mem [0:`SNOW_LINES-1];

  // block rams power up cleared
  initial
  begin
    for (int i = 0; i < `SNOW_LINES; i++)
      mem[i] = '0;
  end

  // read port, output held while re is low
  always_ff @(posedge rclk)
  begin
    if (re)
      rdata <= mem[raddr];
  end

  // write port on its own clock
  always_ff @(posedge wclk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

endmodule

/* flist.f */
+incdir+.
snowball_pkg.sv
dual_clock_ram.sv
snowball_cache.sv
main_mem.sv
snowball_top.sv
tb_snowball.sv

/* main_mem.sv */
`timescale 1ns/1ns
`include "snowball_params.svh"

module main_mem (
  input  logic                   MCU_CLK,
  input  logic                   RST,
  input  snowball_pkg::mem_req_t mem_req,
  output snowball_pkg::mem_rsp_t mem_rsp
);

  localparam int LAT_W = $clog2(`SNOW_MEM_LAT + 1);

  logic [31:0]             mem [0:`SNOW_MEM_WORDS-1];
  logic [`SNOW_MEM_AW-1:0] widx;
  logic [LAT_W-1:0]        lat_cnt;
  logic                    due;
  logic                    ack_q;
  logic [31:0]             rdata_q;

  initial
  begin
    for (int i = 0; i < `SNOW_MEM_WORDS; i++)
      mem[i] = '0;
  end

  assign widx = mem_req.addr[`SNOW_MEM_AW+1:2];     // word addressed
  assign due  = mem_req.act && !ack_q &&
                (lat_cnt == LAT_W'(`SNOW_MEM_LAT - 1));

  assign mem_rsp = '{ack: ack_q, rdata: rdata_q};

  // --------------------------------------------------
  // latency counter

  always_ff @(posedge MCU_CLK)
  begin
    if (!RST)
    begin
      lat_cnt <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= due;
      if (!mem_req.act || due)
        lat_cnt <= '0;
      else if (!ack_q)
        lat_cnt <= lat_cnt + 1'b1;    // ack cycle is not counted
    end
  end

  // --------------------------------------------------
  // storage

  always_ff @(posedge MCU_CLK)
  begin
    if (due)
    begin
      if (mem_req.we)
        mem[widx] <= mem_req.wdata;
      rdata_q <= mem[widx];
    end
  end

endmodule

/* snowball_cache.sv */
`timescale 1ns/1ns
`include "snowball_params.svh"

module snowball_cache (
  input  logic                   CPU_CLK,
  input  logic                   MCU_CLK,
  input  logic                   RST,
  input  snowball_pkg::cpu_req_t cpu_req,
  input  logic                   req_en,
  input  logic                   cache_inhibit,
  input  logic                   VMEM_ACT,
  input  logic                   WE_TLB,
  input  logic                   dma_mcu_access,
  input  snowball_pkg::mem_rsp_t mem_rsp,
  output logic [31:0]            rdata,
  output logic                   busy,
  output logic                   MMU_FAULT,
  output snowball_pkg::mem_req_t mem_req
);

  import snowball_pkg::*;

  // cpu domain
  cpu_req_t                cyc_req;      // request in its lookup cycle
  logic                    cyc_vmem;
  logic                    look_vld;
  logic                    tlb_vld;
  cpu_req_t                x_req;        // held for the mcu side while busy
  logic                    x_tlb;
  logic                    req_tog;
  logic [2:0]              rsp_sync;
  logic                    done;
  logic                    ghost_vld;
  logic [29:0]             ghost_addr;   // word address
  logic [31:0]             ghost_data;

  logic                    accept;
  logic [31:0]             data_rd;
  ctag_t                   ctag_rd;
  tlb_entry_t              tlb_rd;
  logic [`SNOW_TAG_W-1:0]  eff_ptag;
  logic [31:0]             paddr;
  logic [`SNOW_CTAG_W-1:0] exp_ctag;
  logic                    fault;
  logic                    tag_hit;
  logic                    ghost_line;
  logic                    ghost_match;
  logic                    hit;
  logic                    launch;

  // mcu domain
  logic [2:0]              req_sync;
  logic                    m_start;
  mem_req_t                mreq;
  logic                    m_beat;       // second word of the pair
  logic                    m_ack;
  logic                    m_last;
  logic                    rsp_tog;
  logic [31:0]             m_word;
  logic [31:0]             m_other;
  logic                    fill_we;
  logic [`SNOW_IDX_W-1:0]  fill_idx;
  logic [31:0]             fill_data;
  ctag_t                   fill_tag;
  tlb_entry_t              tlb_wr;
  logic                    tlb_we;

  // --------------------------------------------------
  // rams, read in the pre-cycle on CPU_CLK

  dual_clock_ram #(.payload_t(logic [31:0])) data_ram (
    .rclk  (CPU_CLK),
    .raddr (cpu_req.addr[9:2]),
    .re    (accept),
    .wclk  (MCU_CLK),
    .waddr (fill_idx),
    .we    (fill_we),
    .wdata (fill_data),
    .rdata (data_rd)
  );

  dual_clock_ram #(.payload_t(ctag_t)) tag_ram (
    .rclk  (CPU_CLK),
    .raddr (cpu_req.addr[9:2]),
    .re    (accept),
    .wclk  (MCU_CLK),
    .waddr (fill_idx),
    .we    (fill_we),
    .wdata (fill_tag),
    .rdata (ctag_rd)
  );

  dual_clock_ram #(.payload_t(tlb_entry_t)) tlb_ram (
    .rclk  (CPU_CLK),
    .raddr (cpu_req.addr[17:10]),
    .re    (accept),
    .wclk  (MCU_CLK),
    .waddr (x_req.addr[7:0]),
    .we    (tlb_we),
    .wdata (tlb_wr),
    .rdata (tlb_rd)
  );

  // --------------------------------------------------
  // lookup cycle

  assign accept = (req_en || WE_TLB) && !cache_inhibit && !busy && !launch;
  assign done   = rsp_sync[1] ^ rsp_sync[2];

  assign fault    = cyc_vmem && (tlb_rd.vtag != cyc_req.addr[31:18]);
  assign eff_ptag = cyc_vmem ? tlb_rd.ptag : cyc_req.addr[31:18];
  assign paddr    = {eff_ptag, cyc_req.addr[17:0]};
  assign exp_ctag = paddr[31:10];
  assign tag_hit  = (ctag_rd == exp_ctag);

  // ghost line may still be in flight to the ram
  assign ghost_line  = ghost_vld && (ghost_addr[7:0] == paddr[9:2]);
  assign ghost_match = ghost_line && (ghost_addr == paddr[31:2]);
  assign hit         = ghost_line ? ghost_match : tag_hit;

  assign launch = (look_vld && !fault && (cyc_req.we || !hit)) || tlb_vld;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      look_vld  <= 1'b0;
      tlb_vld   <= 1'b0;
      busy      <= 1'b0;
      MMU_FAULT <= 1'b0;
      rdata     <= '0;
      req_tog   <= 1'b0;
      rsp_sync  <= '0;
      ghost_vld <= 1'b0;
    end
    else
    begin
      look_vld <= accept && !WE_TLB;
      tlb_vld  <= accept && WE_TLB;
      rsp_sync <= {rsp_sync[1:0], rsp_tog};

      if (look_vld)
        MMU_FAULT <= fault;
      else if (tlb_vld)
        MMU_FAULT <= 1'b0;

      if (look_vld && !cyc_req.we && !fault && hit)
        rdata <= ghost_match ? ghost_data : data_rd;
      else if (done && !x_tlb && !x_req.we)
        rdata <= m_word;               // missed word

      if (look_vld || tlb_vld)
        ghost_vld <= 1'b0;             // covers the next lookup only

      if (launch)
      begin
        busy    <= 1'b1;
        req_tog <= !req_tog;
      end
      else if (done)
      begin
        busy <= 1'b0;
        if (!x_tlb)
          ghost_vld <= 1'b1;
      end
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      cyc_req  <= cpu_req;
      cyc_vmem <= VMEM_ACT;
    end
    if (launch)
    begin
      x_req.addr  <= tlb_vld ? cyc_req.addr : paddr;
      x_req.wdata <= cyc_req.wdata;
      x_req.we    <= cyc_req.we && !tlb_vld;
      x_tlb       <= tlb_vld;
    end
    if (done && !x_tlb)
    begin
      if (x_req.we)
      begin
        ghost_addr <= x_req.addr[31:2];
        ghost_data <= x_req.wdata;
      end
      else
      begin
        ghost_addr <= {x_req.addr[31:3], !x_req.addr[2]};   // pair partner
        ghost_data <= m_other;
      end
    end
  end

  // --------------------------------------------------
  // memory side on MCU_CLK

  assign m_start = req_sync[1] ^ req_sync[2];
  assign m_ack   = mem_rsp.ack && mreq.act;
  assign m_last  = m_ack && (mreq.we || m_beat);

  // tlb writes finish here, main memory never sees them
  assign tlb_we      = m_start && x_tlb;
  assign tlb_wr.ptag = x_req.wdata[16 +: `SNOW_TAG_W];
  assign tlb_wr.vtag = x_req.wdata[0 +: `SNOW_TAG_W];

  assign mem_req = '{addr:  mreq.addr,
                     wdata: mreq.wdata,
                     we:    mreq.we,
                     act:   mreq.act && dma_mcu_access};

  always_ff @(posedge MCU_CLK)
  begin
    if (!RST)
    begin
      req_sync <= '0;
      mreq     <= '0;
      m_beat   <= 1'b0;
      rsp_tog  <= 1'b0;
      fill_we  <= 1'b0;
    end
    else
    begin
      req_sync <= {req_sync[1:0], req_tog};
      fill_we  <= m_ack;

      if (m_start && !x_tlb)
      begin
        mreq.addr  <= x_req.addr;
        mreq.wdata <= x_req.wdata;
        mreq.we    <= x_req.we;
        mreq.act   <= 1'b1;
        m_beat     <= 1'b0;
      end
      else if (m_ack)
      begin
        if (mreq.we || m_beat)
          mreq.act <= 1'b0;
        else
        begin
          mreq.addr[2] <= !mreq.addr[2];   // act stays up for the partner
          m_beat       <= 1'b1;
        end
      end

      if (tlb_we || m_last)
        rsp_tog <= !rsp_tog;
    end
  end

  // ram write stage, last word lands one cycle after the toggle
  always_ff @(posedge MCU_CLK)
  begin
    if (m_ack)
    begin
      fill_idx  <= mreq.addr[9:2];
      fill_data <= mreq.we ? mreq.wdata : mem_rsp.rdata;
      fill_tag  <= ctag_t'(mreq.addr[31:10]);
      if (!mreq.we && !m_beat)
        m_word <= mem_rsp.rdata;
      if (!mreq.we && m_beat)
        m_other <= mem_rsp.rdata;
    end
  end

endmodule

/* snowball_params.svh */
`ifndef SNOWBALL_PARAMS_SVH
`define SNOWBALL_PARAMS_SVH

// --------------------------------------------------
// word and line geometry

`define SNOW_WORD_W     32      // cpu and memory data word
`define SNOW_IDX_W      8       // cache line / tlb entry index
`define SNOW_LINES      256     // lines per ram, 1 << SNOW_IDX_W

// --------------------------------------------------
// address split

// va[31:18] page tag, va[17:10] tlb index, va[9:2] line index
`define SNOW_TAG_W      14      // virtual and physical page tag
`define SNOW_CTAG_W     22      // ptag plus page index

// --------------------------------------------------
// main memory model

`define SNOW_MEM_WORDS  4096    // depth in words
`define SNOW_MEM_AW     12      // word index width
`define SNOW_MEM_LAT    3       // mcu cycles act to ack

`endif

/* snowball_pkg.sv */
`include "snowball_params.svh"

package snowball_pkg;

  // --------------------------------------------------
  // cpu request

  typedef struct packed {
    logic [`SNOW_WORD_W-1:0] addr;
    logic [`SNOW_WORD_W-1:0] wdata;
    logic                    we;
  } cpu_req_t;

  // --------------------------------------------------
  // ram payloads

  // tag of a cached line, same bits as pa[31:10]
  typedef struct packed {
    logic [`SNOW_TAG_W-1:0] ptag;
    logic [`SNOW_IDX_W-1:0] pidx;
  } ctag_t;

  typedef struct packed {
    logic [`SNOW_TAG_W-1:0] ptag;   // upper half of the written word
    logic [`SNOW_TAG_W-1:0] vtag;
  } tlb_entry_t;

  // --------------------------------------------------
  // memory port

  typedef struct packed {
    logic [`SNOW_WORD_W-1:0] addr;
    logic [`SNOW_WORD_W-1:0] wdata;
    logic                    we;
    logic                    act;   // held until ack
  } mem_req_t;

  typedef struct packed {
    logic                    ack;   // single mcu cycle
    logic [`SNOW_WORD_W-1:0] rdata;
  } mem_rsp_t;

endpackage

/* snowball_top.sv */
`timescale 1ns/1ns

module snowball_top (
  input  logic                   CPU_CLK,
  input  logic                   MCU_CLK,
  input  logic                   RST,
  input  snowball_pkg::cpu_req_t cpu_req,
  input  logic                   req_en,
  input  logic                   cache_inhibit,
  input  logic                   VMEM_ACT,
  input  logic                   WE_TLB,
  input  logic                   dma_mcu_access,
  output logic [31:0]            rdata,
  output logic                   busy,
  output logic                   MMU_FAULT
);

  import snowball_pkg::*;

  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  snowball_cache cache0 (
    .CPU_CLK        (CPU_CLK),
    .MCU_CLK        (MCU_CLK),
    .RST            (RST),
    .cpu_req        (cpu_req),
    .req_en         (req_en),
    .cache_inhibit  (cache_inhibit),
    .VMEM_ACT       (VMEM_ACT),
    .WE_TLB         (WE_TLB),
    .dma_mcu_access (dma_mcu_access),
    .mem_rsp        (mem_rsp),
    .rdata          (rdata),
    .busy           (busy),
    .MMU_FAULT      (MMU_FAULT),
    .mem_req        (mem_req)
  );

  main_mem mem0 (
    .MCU_CLK (MCU_CLK),
    .RST     (RST),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

/* tb_snowball.sv */
`timescale 1ns/1ns
`include "snowball_params.svh"

module tb_snowball;

  import snowball_pkg::*;

  localparam int     CPU_PER = 10;
  localparam int     MCU_PER = 14;
  localparam int     N_PHYS  = 300;
  localparam int     N_TLB   = 32;
  localparam int     N_VIRT  = 200;
  localparam int     N_INH   = 40;
  localparam int     N_REQ   = 3 * N_PHYS + N_TLB + 2 * N_VIRT + 2 * N_INH;
  localparam longint WD_NS   = 20 * CPU_PER +
                               longint'(N_REQ) * (40 * CPU_PER + `SNOW_MEM_LAT * MCU_PER);

  logic        CPU_CLK = 1'b0;
  logic        MCU_CLK = 1'b0;
  logic        RST;
  cpu_req_t    cpu_req;
  logic        req_en;
  logic        cache_inhibit;
  logic        VMEM_ACT;
  logic        WE_TLB;
  logic        dma_mcu_access;
  logic [31:0] rdata;
  logic        busy;
  logic        MMU_FAULT;

  // reference model
  logic [31:0]            mem_img  [0:`SNOW_MEM_WORDS-1];
  logic [`SNOW_TAG_W-1:0] tlb_ptag [0:`SNOW_LINES-1];
  logic [`SNOW_TAG_W-1:0] tlb_vtag [0:`SNOW_LINES-1];
  logic                   tlb_used [0:`SNOW_LINES-1];
  int                     tlb_list [$];

  int   errors = 0;
  int   checks = 0;
  logic saw_busy;

  snowball_top dut0 (
    .CPU_CLK        (CPU_CLK),
    .MCU_CLK        (MCU_CLK),
    .RST            (RST),
    .cpu_req        (cpu_req),
    .req_en         (req_en),
    .cache_inhibit  (cache_inhibit),
    .VMEM_ACT       (VMEM_ACT),
    .WE_TLB         (WE_TLB),
    .dma_mcu_access (dma_mcu_access),
    .rdata          (rdata),
    .busy           (busy),
    .MMU_FAULT      (MMU_FAULT)
  );

  always #(CPU_PER / 2) CPU_CLK = !CPU_CLK;
  always #(MCU_PER / 2) MCU_CLK = !MCU_CLK;

  initial
  begin
    #(WD_NS);
    $display("watchdog expired after %0d ns, run did not finish", WD_NS);
    $display("checks %0d errors %0d", checks, errors + 1);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------------------------------------
  // helpers

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // main memory decodes pa[13:2] only
  function automatic int word_of(input logic [31:0] pa);
    return int'(pa[`SNOW_MEM_AW+1:2]);
  endfunction

  task automatic issue(input string name, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic we, input logic tlb, input logic vmem, input logic inhibit);
    int cycles;
    @(negedge CPU_CLK);
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    cpu_req.we    = we;
    req_en        = !tlb;
    WE_TLB        = tlb;
    VMEM_ACT      = vmem;
    cache_inhibit = inhibit;
    @(negedge CPU_CLK);
    req_en        = 1'b0;
    WE_TLB        = 1'b0;
    cache_inhibit = 1'b0;
    @(negedge CPU_CLK);                          // lookup result registered
    saw_busy = busy;
    cycles   = 0;
    while (busy && cycles < 200)
    begin
      @(negedge CPU_CLK);
      dma_mcu_access = ($urandom % 8) != 0;      // occasional grant loss
      cycles++;
    end
    checks++;
    assert (!busy)
    else
    begin
      errors++;
      $display("%s: busy still high after %0d cycles", name, cycles);
    end
  endtask

  task automatic read_check(input string name, input logic [31:0] addr, input logic vmem,
                            input logic [31:0] exp, input logic must_hit);
    issue(name, addr, 32'h0, 1'b0, 1'b0, vmem, 1'b0);
    compare({name, "_data"}, exp, rdata);
    compare({name, "_fault"}, 32'h0, MMU_FAULT);
    if (must_hit)
      compare({name, "_busy"}, 32'h0, saw_busy);
  endtask

  // --------------------------------------------------
  // stimulus

  initial
  begin
    logic [31:0]            addr;
    logic [31:0]            wd;
    logic [31:0]            pa;
    logic [`SNOW_TAG_W-1:0] vtag;
    logic                   we;
    logic                   bad;
    logic                   miss;
    int                     idx;

    void'($urandom(32'h124a_45c6));
    RST            = 1'b0;
    cpu_req        = '0;
    req_en         = 1'b0;
    cache_inhibit  = 1'b0;
    VMEM_ACT       = 1'b0;
    WE_TLB         = 1'b0;
    dma_mcu_access = 1'b1;
    for (int i = 0; i < `SNOW_MEM_WORDS; i++)
      mem_img[i] = '0;
    for (int i = 0; i < `SNOW_LINES; i++)
      tlb_used[i] = 1'b0;

    repeat (10) @(negedge CPU_CLK);
    RST = 1'b1;
    @(negedge CPU_CLK);
    compare("reset_busy", 32'h0, busy);
    compare("reset_fault", 32'h0, MMU_FAULT);
    compare("reset_act", 32'h0, dut0.mem_req.act);

    // physical mode with a small window half the time for hits
    for (int n = 0; n < N_PHYS; n++)
    begin
      addr = 32'(($urandom % 2) ? $urandom % 128 : $urandom % `SNOW_MEM_WORDS) << 2;
      if ($urandom % 2)
      begin
        wd = $urandom;
        issue("phys_write", addr, wd, 1'b1, 1'b0, 1'b0, 1'b0);
        mem_img[word_of(addr)] = wd;
        compare("phys_write_busy", 32'h1, saw_busy);
      end
      else
      begin
        read_check("phys_read", addr, 1'b0, mem_img[word_of(addr)], 1'b0);
        miss = saw_busy;
        if (miss)
          read_check("pair_hit", addr ^ 32'h4, 1'b0, mem_img[word_of(addr ^ 32'h4)], 1'b1);
        if (miss || ($urandom % 4) == 0)
          read_check("repeat_hit", addr, 1'b0, mem_img[word_of(addr)], 1'b1);
      end
    end

    // tlb load with distinct entries
    for (int n = 0; n < N_TLB; n++)
    begin
      idx = $urandom % `SNOW_LINES;
      while (tlb_used[idx])
        idx = (idx + 1) % `SNOW_LINES;
      tlb_ptag[idx] = `SNOW_TAG_W'($urandom % 4);
      tlb_vtag[idx] = `SNOW_TAG_W'($urandom);
      wd = {2'b00, tlb_ptag[idx], 2'b00, tlb_vtag[idx]};
      issue("tlb_write", 32'(idx), wd, 1'b0, 1'b1, 1'b0, 1'b0);
      tlb_used[idx] = 1'b1;
      tlb_list.push_back(idx);
      compare("tlb_write_busy", 32'h1, saw_busy);
    end

    // virtual mode with a wrong vtag on a quarter of the accesses
    for (int n = 0; n < N_VIRT; n++)
    begin
      idx  = tlb_list[$urandom % tlb_list.size()];
      bad  = ($urandom % 4) == 0;
      vtag = bad ? tlb_vtag[idx] ^ `SNOW_TAG_W'(1 + $urandom % 16383) : tlb_vtag[idx];
      addr = {vtag, 8'(idx), 8'($urandom), 2'b00};
      pa   = {tlb_ptag[idx], addr[17:0]};
      we   = 1'($urandom);
      wd   = $urandom;
      if (bad)
      begin
        issue("virt_fault", addr, wd, we, 1'b0, 1'b1, 1'b0);
        compare("virt_fault_flag", 32'h1, MMU_FAULT);
        compare("virt_fault_busy", 32'h0, saw_busy);
        read_check("virt_after_fault", {tlb_vtag[idx], addr[17:0]}, 1'b1,
                   mem_img[word_of(pa)], 1'b0);
      end
      else if (we)
      begin
        issue("virt_write", addr, wd, 1'b1, 1'b0, 1'b1, 1'b0);
        mem_img[word_of(pa)] = wd;
        compare("virt_write_fault", 32'h0, MMU_FAULT);
        read_check("virt_write_phys", pa, 1'b0, mem_img[word_of(pa)], 1'b1);   // line under ptag
      end
      else
      begin
        read_check("virt_read", addr, 1'b1, mem_img[word_of(pa)], 1'b0);
        read_check("virt_read_phys", pa, 1'b0, mem_img[word_of(pa)], 1'b1);
      end
    end

    // inhibited strobes
    for (int n = 0; n < N_INH; n++)
    begin
      addr = 32'($urandom % 128) << 2;
      wd   = ~mem_img[word_of(addr)];           // differs from the stored word
      issue("inhibit_write", addr, wd, 1'b1, 1'b0, 1'b0, 1'b1);
      compare("inhibit_busy", 32'h0, saw_busy);
      read_check("inhibit_read", addr, 1'b0, mem_img[word_of(addr)], 1'b0);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
